// ==== mat_engine_pkg.sv ====
// Matrix engine shared definitions
package mat_engine_pkg;

    localparam int mat_dim    = 4;
    localparam int elem_count = mat_dim * mat_dim;
    localparam int elem_w     = 8;
    localparam int res_w      = 16;

    // Buffer depth and the producer's starting credit count
    localparam int fifo_depth = 2;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

    // Consumer credits held by the issuer
    localparam int credit_max = fifo_depth + 4;
    localparam int credit_w   = $clog2(credit_max + 1);

    localparam logic [95:0] pattern_init = 96'h1234_5678_9abc_def0_1234_5678;

    typedef logic [3:0] idx_t;  // Row in [3:2], column in [1:0]

    typedef enum logic [2:0] {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_mul   = 3'd2,
        op_mac   = 3'd3,
        op_mix   = 3'd4,
        op_max   = 3'd5,
        op_min   = 3'd6,
        op_cross = 3'd7
    } op_t;

    typedef struct packed {
        logic [elem_count*elem_w-1:0] a;  // Element k at bits 8k
        logic [elem_count*elem_w-1:0] b;
        op_t                          op;
    } job_t;

    typedef struct packed {
        logic [elem_count*res_w-1:0] mat;  // Element k at bits 16k
        op_t                         op;
    } result_t;

    typedef struct packed {
        logic [7:0] c;
        logic [7:0] d;
        logic [7:0] e;
    } coeff_t;

endpackage

// ==== sync_fifo.sv ====
// Small synchronous FIFO
`timescale 1ns/100ps

module sync_fifo
    import mat_engine_pkg::*;
#(
    parameter type payload_t = job_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t rdata,
    output logic     not_empty,
    output logic     not_full
);

    payload_t mem [fifo_depth];

    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;

    assign rdata     = mem[rd_ptr];  // Head visible the cycle after its push
    assign not_empty = (count != '0);
    assign not_full  = (count != fifo_cnt_w'(fifo_depth));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

// ==== coeff_pattern_gen.sv ====
// Coefficient pattern generator
`timescale 1ns/100ps

module coeff_pattern_gen
    import mat_engine_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   step,
    output coeff_t coeff
);

    logic [95:0] state;
    logic        fb_bit;

    // Three-tap feedback into bit 0
    assign fb_bit = state[95] ^ state[63] ^ state[31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= pattern_init;
        end else if (step) begin
            state <= {state[94:0], fb_bit};
        end
    end

    // Coefficients come straight from the current state
    assign coeff.c = state[31:24];
    assign coeff.d = state[23:16];
    assign coeff.e = state[15:8];

endmodule

// ==== elem_operator.sv ====
// Element operator
`timescale 1ns/100ps

module elem_operator
    import mat_engine_pkg::*;
(
    input  op_t               op,
    input  logic [elem_w-1:0] a,
    input  logic [elem_w-1:0] b,
    input  coeff_t            coeff,
    output logic [res_w-1:0]  y
);

    logic [res_w-1:0] a_x;
    logic [res_w-1:0] b_x;
    logic [res_w-1:0] c_x;
    logic [res_w-1:0] d_x;
    logic [res_w-1:0] prod_ab;
    logic [res_w-1:0] prod_ac;
    logic [res_w-1:0] prod_bd;

    // Zero-extend everything to the result width
    assign a_x = res_w'(a);
    assign b_x = res_w'(b);
    assign c_x = res_w'(coeff.c);
    assign d_x = res_w'(coeff.d);

    assign prod_ab = a_x * b_x;
    assign prod_ac = a_x * c_x;
    assign prod_bd = b_x * d_x;

    always_comb begin
        case (op)
            op_add: begin
                y = a_x + b_x;
            end
            op_sub: begin
                y = a_x - b_x;  // Wraps as two's complement
            end
            op_mul: begin
                y = prod_ab;
            end
            op_mac: begin
                y = prod_ab + c_x;
            end
            op_mix: begin
                // Upper byte from a, lower from b
                y = {a ^ coeff.d, b ^ coeff.e};
            end
            op_max: begin
                y = (a >= b) ? a_x : b_x;
            end
            op_min: begin
                y = (a <= b) ? a_x : b_x;
            end
            op_cross: begin
                y = prod_ac + prod_bd;  // Truncated to 16 bits
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

// ==== matrix_sequencer.sv ====
// Matrix element sequencer
`timescale 1ns/100ps

module matrix_sequencer
    import mat_engine_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  job_t              job_head,
    input  logic              job_avail,
    output logic              job_pop,
    output logic [elem_w-1:0] elem_a,
    output logic [elem_w-1:0] elem_b,
    output op_t               op,
    input  logic [res_w-1:0]  elem_res,
    output logic              coeff_step,
    output logic              res_push,
    output result_t           res_data,
    input  logic              res_room
);

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_hold
    } state_t;

    state_t  state;
    idx_t    idx;
    job_t    job_q;  // Latched job
    result_t res_q;  // Result being assembled

    logic last_elem;

    assign last_elem = (idx == idx_t'(elem_count - 1));

    // Row-major walk with the row in idx[3:2] and the column in idx[1:0]
    assign elem_a = job_q.a[idx*elem_w +: elem_w];
    assign elem_b = job_q.b[idx*elem_w +: elem_w];
    assign op     = job_q.op;

    assign job_pop    = (state == st_idle) && job_avail;
    assign coeff_step = (state == st_compute);  // One step per element
    assign res_push   = (state == st_hold) && res_room;
    assign res_data   = res_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            idx   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (job_pop) begin
                        idx   <= '0;
                        state <= st_compute;
                    end
                end
                st_compute: begin
                    if (last_elem) begin
                        state <= st_hold;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                st_hold: begin
                    // Stays here while the result FIFO is full
                    if (res_push) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Job and result payload registers
    always_ff @(posedge clk) begin
        if (job_pop) begin
            job_q    <= job_head;
            res_q.op <= job_head.op;
        end
        if (state == st_compute) begin
            res_q.mat[idx*res_w +: res_w] <= elem_res;
        end
    end

endmodule

// ==== result_credit_issuer.sv ====
// Result credit issuer
`timescale 1ns/100ps

module result_credit_issuer
    import mat_engine_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    res_credit,
    input  result_t fifo_head,
    input  logic    fifo_avail,
    output logic    fifo_pop,
    output logic    res_valid,
    output result_t res
);

    logic [credit_w-1:0] credits;

    // Release only against a held credit
    assign fifo_pop = (credits != '0) && fifo_avail;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits   <= '0;
            res_valid <= 1'b0;
        end else begin
            if (res_credit && !fifo_pop && credits != credit_w'(credit_max)) begin
                credits <= credits + 1'b1;
            end else if (!res_credit && fifo_pop) begin
                credits <= credits - 1'b1;
            end
            res_valid <= fifo_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            res <= fifo_head;
        end
    end

endmodule

// ==== matrix_engine_top.sv ====
// Element-wise matrix engine
`timescale 1ns/100ps

module matrix_engine_top
    import mat_engine_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    job_valid,
    input  job_t    job,
    output logic    job_credit,
    input  logic    res_credit,
    output logic    res_valid,
    output result_t res
);

    // Job path
    job_t job_head;
    logic job_not_empty;
    logic job_not_full;  // Watched by the assertions
    logic job_pop;

    // Element datapath
    logic [elem_w-1:0] elem_a;
    logic [elem_w-1:0] elem_b;
    logic [res_w-1:0]  elem_res;
    op_t               seq_op;
    coeff_t            coeff;
    logic              coeff_step;

    // Result path
    result_t seq_res_data;
    logic    res_push;
    result_t res_head;
    logic    res_not_empty;
    logic    res_not_full;
    logic    res_pop;

    assign job_credit = job_pop;  // A slot frees on each pop

    sync_fifo #(.payload_t(job_t)) u_job_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (job_valid),
        .wdata     (job),
        .pop       (job_pop),
        .rdata     (job_head),
        .not_empty (job_not_empty),
        .not_full  (job_not_full)
    );

    matrix_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .job_head   (job_head),
        .job_avail  (job_not_empty),
        .job_pop    (job_pop),
        .elem_a     (elem_a),
        .elem_b     (elem_b),
        .op         (seq_op),
        .elem_res   (elem_res),
        .coeff_step (coeff_step),
        .res_push   (res_push),
        .res_data   (seq_res_data),
        .res_room   (res_not_full)
    );

    elem_operator u_op (
        .op    (seq_op),
        .a     (elem_a),
        .b     (elem_b),
        .coeff (coeff),
        .y     (elem_res)
    );

    coeff_pattern_gen u_gen (
        .clk   (clk),
        .rst   (rst),
        .step  (coeff_step),
        .coeff (coeff)
    );

    sync_fifo #(.payload_t(result_t)) u_res_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (res_push),
        .wdata     (seq_res_data),
        .pop       (res_pop),
        .rdata     (res_head),
        .not_empty (res_not_empty),
        .not_full  (res_not_full)
    );

    result_credit_issuer u_issuer (
        .clk        (clk),
        .rst        (rst),
        .res_credit (res_credit),
        .fifo_head  (res_head),
        .fifo_avail (res_not_empty),
        .fifo_pop   (res_pop),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule

// ==== matrix_engine_sva.sv ====
// Bound protocol checks for the matrix engine
`timescale 1ns/100ps

module matrix_engine_sva
    import mat_engine_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic job_valid,
    input logic job_not_full,
    input logic job_credit,
    input logic res_credit,
    input logic res_valid
);

    int fail_count = 0;  // Assertion failures so far
    int job_fill;        // Jobs accepted and not yet popped
    int res_held;        // Consumer credits not yet answered by a result

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            job_fill <= 0;
            res_held <= 0;
        end else begin
            job_fill <= job_fill + int'(job_valid) - int'(job_credit);
            res_held <= res_held + int'(res_credit) - int'(res_valid);
        end
    end

    // Quiet outputs through reset and on the first edge after release
    a_reset_quiet: assert property (@(posedge clk) rst |=> !res_valid && !job_credit)
        else begin
            $error("res_valid or job_credit high during or right after reset");
            fail_count++;
        end

    // A full job buffer means the producer spent a credit it did not have
    a_job_room: assert property (@(posedge clk) disable iff (rst) job_valid |-> job_not_full)
        else begin
            $error("job_valid while the job FIFO is full");
            fail_count++;
        end

    a_res_credit: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> res_held > 0)
        else begin
            $error("res_valid with no consumer credit held");
            fail_count++;
        end

    a_credit_source: assert property (@(posedge clk) disable iff (rst)
        job_credit |-> job_fill > 0)  // Slot freed only for an accepted job
        else begin
            $error("job_credit while no accepted job is waiting");
            fail_count++;
        end

endmodule

bind matrix_engine_top matrix_engine_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .job_valid    (job_valid),
    .job_not_full (job_not_full),
    .job_credit   (job_credit),
    .res_credit   (res_credit),
    .res_valid    (res_valid)
);

// ==== tb_matrix_engine.sv ====
// Matrix engine testbench
`timescale 1ns/100ps

module tb_matrix_engine
    import mat_engine_pkg::*;
();

    localparam int job_total    = 24;
    localparam int stall_cycles = 100;
    localparam int cycle_limit  = job_total * 40 + stall_cycles + 200;

    logic    clk;
    logic    rst;
    logic    job_valid;
    job_t    job;
    logic    job_credit;
    logic    res_credit;
    logic    res_valid;
    result_t res;

    logic [95:0] model_state = pattern_init;  // Mirrors the coefficient generator
    result_t     exp_q[$];
    string       exp_name[$];
    int          jobs_sent    = 0;
    int          credits_back = 0;  // job_credit pulses seen
    int          granted      = 0;
    int          received     = 0;
    int          cycle_count  = 0;
    int          stall_count  = 0;
    logic        in_stall     = 1'b0;

    matrix_engine_top dut (
        .clk        (clk),
        .rst        (rst),
        .job_valid  (job_valid),
        .job        (job),
        .job_credit (job_credit),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res        (res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("TEST FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic drive_credit(input logic give);
        res_credit = give;
        if (give) begin
            granted++;
        end
    endtask

    // Element operator table
    function automatic logic [15:0] ref_elem(input op_t op, input logic [7:0] a, b, c, d, e);
        int ai;
        int bi;
        ai = a;
        bi = b;
        case (op)
            op_add:   return 16'(ai + bi);
            op_sub:   return 16'(ai - bi);
            op_mul:   return 16'(ai * bi);
            op_mac:   return 16'(ai * bi + int'(c));
            op_mix:   return {a ^ d, b ^ e};
            op_max:   return (a > b) ? 16'(a) : 16'(b);
            op_min:   return (a < b) ? 16'(a) : 16'(b);
            op_cross: return 16'(ai * int'(c) + bi * int'(d));
            default:  return 16'h0;
        endcase
    endfunction

    // Predicts one job's result and advances the model generator
    task automatic predict_result(input job_t j, output result_t r);
        logic [7:0] a;
        logic [7:0] b;
        int         k;
        r.op  = j.op;
        r.mat = '0;
        for (k = 0; k < elem_count; k++) begin
            a = j.a[k*elem_w +: elem_w];
            b = j.b[k*elem_w +: elem_w];
            r.mat[k*res_w +: res_w] = ref_elem(j.op, a, b, model_state[31:24],
                                               model_state[23:16], model_state[15:8]);
            model_state = {model_state[94:0],
                           model_state[95] ^ model_state[63] ^ model_state[31]};
        end
    endtask

    task automatic check_result();
        result_t exp;
        string   name;
        int      k;
        assert (exp_q.size() != 0 && granted > received)
            else abort_run("res_valid without an outstanding job and consumer credit");
        exp  = exp_q.pop_front();
        name = exp_name.pop_front();
        assert (res.op == exp.op) else begin
            $display("MISMATCH test=%s field=op expected=%0d actual=%0d", name, exp.op, res.op);
            abort_run("result carries the wrong operation code");
        end
        for (k = 0; k < elem_count; k++) begin
            assert (res.mat[k*res_w +: res_w] == exp.mat[k*res_w +: res_w]) else begin
                $display("MISMATCH test=%s elem=%0d row=%0d col=%0d expected=%h actual=%h",
                         name, k, k / mat_dim, k % mat_dim,
                         exp.mat[k*res_w +: res_w], res.mat[k*res_w +: res_w]);
                abort_run("result element differs from the reference model");
            end
        end
        received++;
    endtask

    // Producer spending only the credits it holds
    initial begin
        job_t    j;
        result_t r;
        op_t     op;
        void'($urandom(32'h3e1b));
        @(negedge rst);
        repeat (10) @(posedge clk);  // Idle window with credits but no jobs
        while (jobs_sent < job_total) begin
            @(posedge clk);
            #1;
            if (fifo_depth + credits_back - jobs_sent > 0 && $urandom_range(3) != 0) begin
                op   = op_t'(jobs_sent % 8);  // Every code three times
                j.a  = {$urandom, $urandom, $urandom, $urandom};
                j.b  = {$urandom, $urandom, $urandom, $urandom};
                j.op = op;
                predict_result(j, r);
                exp_q.push_back(r);
                exp_name.push_back($sformatf("job%0d_%s", jobs_sent, op.name()));
                job       = j;
                job_valid = 1'b1;
                jobs_sent++;
            end else begin
                job_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1 job_valid = 1'b0;
    end

    // Scoreboard and watchdog on the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            cycle_count++;
            if (job_credit) begin
                credits_back++;
            end
            assert (credits_back <= jobs_sent)
                else abort_run("job_credit returned a slot that no job had used");
            assert (dut.u_sva.fail_count == 0)
                else abort_run("a bound protocol assertion failed");
            if (in_stall) begin
                stall_count++;
                assert (!res_valid)
                    else abort_run("res_valid rose while the consumer gave no credits");
                assert (!(job_credit && stall_count > stall_cycles - 40))
                    else abort_run("job_credit kept pulsing under output back-pressure");
            end
            if (res_valid) begin
                check_result();
            end
            if (cycle_count >= cycle_limit) begin
                abort_run($sformatf("timeout after %0d cycles with %0d of %0d results",
                                    cycle_count, received, job_total));
            end
        end
    end

    // Reset followed by the consumer phases
    initial begin
        rst        = 1'b1;
        job_valid  = 1'b0;
        job        = '0;
        res_credit = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        while (received < 8) begin
            @(posedge clk);
            #1 drive_credit(granted - received < 2);
        end
        while (granted != received) begin  // Drain outstanding credits
            @(posedge clk);
            #1 drive_credit(1'b0);
        end
        in_stall = 1'b1;
        repeat (stall_cycles) @(posedge clk);
        #1 in_stall = 1'b0;
        while (received < job_total) begin
            @(posedge clk);
            #1 drive_credit(granted - received < 2 && cycle_count % 6 == 0);
        end
        // Spare credits with no job left must release nothing
        repeat (2) begin
            @(posedge clk);
            #1 drive_credit(1'b1);
        end
        @(posedge clk);
        #1 drive_credit(1'b0);
        repeat (60) @(posedge clk);
        if (exp_q.size() == 0 && jobs_sent == job_total && dut.u_sva.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run("jobs and results do not balance at the end of the run");
        end
    end

endmodule

// ==== matrix_engine.f ====
mat_engine_pkg.sv
sync_fifo.sv
coeff_pattern_gen.sv
elem_operator.sv
matrix_sequencer.sv
result_credit_issuer.sv
matrix_engine_top.sv
matrix_engine_sva.sv
tb_matrix_engine.sv
